// File: hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int INSTR_W    = 32;
    localparam int REG_ADDR_W = 5;

    // Primary opcode, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL  = 6'b000000,
        OP_REGIMM   = 6'b000001,
        OP_J        = 6'b000010,
        OP_JAL      = 6'b000011,
        OP_BEQ      = 6'b000100,
        OP_BNE      = 6'b000101,
        OP_BLEZ     = 6'b000110,
        OP_BGTZ     = 6'b000111,
        OP_ADDI     = 6'b001000,
        OP_ADDIU    = 6'b001001,
        OP_SLTI     = 6'b001010,
        OP_SLTIU    = 6'b001011,
        OP_ANDI     = 6'b001100,
        OP_ORI      = 6'b001101,
        OP_XORI     = 6'b001110,
        OP_LUI      = 6'b001111,
        OP_SPECIAL2 = 6'b011100,
        OP_LB       = 6'b100000,
        OP_LH       = 6'b100001,
        OP_LW       = 6'b100011,
        OP_LBU      = 6'b100100,
        OP_LHU      = 6'b100101,
        OP_SB       = 6'b101000,
        OP_SH       = 6'b101001,
        OP_SW       = 6'b101011
    } opcode_e;

    // Function field under SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000, FN_SRL   = 6'b000010, FN_SRA     = 6'b000011,
        FN_SLLV = 6'b000100, FN_SRLV  = 6'b000110, FN_SRAV    = 6'b000111,
        FN_JR   = 6'b001000, FN_JALR  = 6'b001001,
        FN_SYSCALL = 6'b001100, FN_BREAK = 6'b001101, FN_SYNC = 6'b001111,
        FN_MFHI = 6'b010000, FN_MTHI  = 6'b010001,
        FN_MFLO = 6'b010010, FN_MTLO  = 6'b010011,
        FN_MULT = 6'b011000, FN_MULTU = 6'b011001,
        FN_DIV  = 6'b011010, FN_DIVU  = 6'b011011,
        FN_ADD  = 6'b100000, FN_ADDU  = 6'b100001,
        FN_SUB  = 6'b100010, FN_SUBU  = 6'b100011,
        FN_AND  = 6'b100100, FN_OR    = 6'b100101,
        FN_XOR  = 6'b100110, FN_NOR   = 6'b100111,
        FN_SLT  = 6'b101010, FN_SLTU  = 6'b101011
    } funct_e;

    // Function field under SPECIAL2
    typedef enum logic [5:0] {
        F2_MADD  = 6'b000000,
        F2_MADDU = 6'b000001,
        F2_MUL   = 6'b000010,
        F2_MSUB  = 6'b000100,
        F2_MSUBU = 6'b000101
    } funct2_e;

    // Branch kind carried in rt under REGIMM
    typedef enum logic [REG_ADDR_W-1:0] {
        RI_BLTZ   = 5'b00000,
        RI_BGEZ   = 5'b00001,
        RI_BLTZAL = 5'b10000,
        RI_BGEZAL = 5'b10001
    } regimm_e;

    // Immediate is {rd, shamt, funct}; jump target is everything below op
    typedef struct packed {
        opcode_e               op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } instr_t;

endpackage

`default_nettype wire

// File: hdl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0, ALU_SUB = 3'd1, ALU_SLT = 3'd2, ALU_SLTU = 3'd3,
        ALU_AND = 3'd4, ALU_NOR = 3'd5, ALU_OR  = 3'd6, ALU_XOR  = 3'd7
    } alu_func_e;

    typedef enum logic [1:0] {
        SFT_LUI = 2'd0, SFT_SLL = 2'd1, SFT_SRA = 2'd2, SFT_SRL = 2'd3
    } sft_func_e;

    // Five sources, so three bits
    typedef enum logic [2:0] {
        OUT_ALU = 3'd0, OUT_SHIFT = 3'd1, OUT_HI = 3'd2, OUT_LO = 3'd3, OUT_MUL = 3'd4
    } out_sel_e;

    typedef enum logic [1:0] {
        REGDST_RT = 2'd0, REGDST_RD = 2'd1, REGDST_RA = 2'd2
    } regdst_e;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'd0, BR_BNE  = 3'd1, BR_BGEZ   = 3'd2, BR_BGTZ   = 3'd3,
        BR_BLEZ = 3'd4, BR_BLTZ = 3'd5, BR_BGEZAL = 3'd6, BR_BLTZAL = 3'd7
    } branch_e;

    typedef enum logic [1:0] {
        JMP_J = 2'd0, JMP_JR = 2'd1, JMP_JAL = 2'd2, JMP_JALR = 2'd3
    } jump_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0, SIZE_HALF = 2'd1, SIZE_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        HILO_MULDIV = 2'd0, HILO_DIV = 2'd1, HILO_REG = 2'd2
    } hilo_sel_e;

    typedef enum logic [1:0] {
        MUL_PLAIN = 2'd0, MUL_ACC_ADD = 2'd1, MUL_ACC_SUB = 2'd2
    } mul_mode_e;

    typedef struct packed {
        logic    regwrite;
        regdst_e regdst;
    } wb_ctrl_t;

    typedef struct packed {
        alu_func_e alu_func;
        sft_func_e sft_func;
        out_sel_e  out_sel;
        logic      alu_srcb_sel_rt;
        logic      sft_srcb_sel_rs;
        logic      sft_srca_sel_imm;
        logic      imm_sign;
        logic      intovf_en;
    } arith_ctrl_t;

    typedef struct packed {
        logic    isbranch;
        branch_e branch;
        logic    isjump;
        jump_e   jump;
        logic    link;
        logic    mips_break;
        logic    syscall;
    } flow_ctrl_t;

    typedef struct packed {
        logic      memreq;
        logic      memwr;
        mem_size_e size;
        logic      rdata_sign;
        logic      memtoreg;
    } mem_ctrl_t;

    typedef struct packed {
        logic      mul_en;
        logic      mul_sign;
        mul_mode_e mul_mode;
        logic      div_en;
        logic      div_sign;
        hilo_sel_e hi_sel;
        hilo_sel_e lo_sel;
        logic      hi_wen;
        logic      lo_wen;
    } muldiv_ctrl_t;

    typedef struct packed {
        arith_ctrl_t  arith;
        flow_ctrl_t   flow;
        mem_ctrl_t    mem;
        muldiv_ctrl_t muldiv;
        wb_ctrl_t     wb;
        logic         reserved_instr;
    } dstage_t;

endpackage

`default_nettype wire

// File: hdl/arith_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module arith_decoder
    import isa_pkg::*, ctrl_pkg::*;
(
    input  instr_t      dinstr,
    output arith_ctrl_t arith,
    output wb_ctrl_t    wb,
    output logic        claim
);

always_comb
begin
    arith = '0;
    wb    = '0;
    claim = 1'b0;
    unique case (dinstr.op)
        OP_SPECIAL:
        begin
            claim = 1'b1;
            wb    = '{regwrite: 1'b1, regdst: REGDST_RD};
            unique case (dinstr.funct)
                FN_ADD, FN_ADDU:  arith.alu_func = ALU_ADD;
                FN_SUB, FN_SUBU:  arith.alu_func = ALU_SUB;
                FN_SLT:           arith.alu_func = ALU_SLT;
                FN_SLTU:          arith.alu_func = ALU_SLTU;
                FN_AND:           arith.alu_func = ALU_AND;
                FN_NOR:           arith.alu_func = ALU_NOR;
                FN_OR:            arith.alu_func = ALU_OR;
                FN_XOR:           arith.alu_func = ALU_XOR;
                FN_SLL, FN_SLLV:  arith.sft_func = SFT_SLL;
                FN_SRA, FN_SRAV:  arith.sft_func = SFT_SRA;
                FN_SRL, FN_SRLV:  arith.sft_func = SFT_SRL;
                FN_MFHI:          arith.out_sel  = OUT_HI;
                FN_MFLO:          arith.out_sel  = OUT_LO;
                FN_MTHI, FN_MTLO: wb             = '0;  // HI/LO write from muldiv
                default:
                begin
                    claim = 1'b0;
                    wb    = '0;
                end
            endcase
            if (dinstr.funct inside {FN_SLL, FN_SRA, FN_SRL, FN_SLLV, FN_SRAV, FN_SRLV})
                arith.out_sel = OUT_SHIFT;
            arith.sft_srcb_sel_rs = dinstr.funct inside {FN_SLLV, FN_SRAV, FN_SRLV};
            // Only register-register ALU ops take rt as operand b
            arith.alu_srcb_sel_rt = claim && wb.regwrite && (arith.out_sel == OUT_ALU);
            arith.intovf_en       = dinstr.funct inside {FN_ADD, FN_SUB};
        end
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
        begin
            claim = 1'b1;
            wb    = '{regwrite: 1'b1, regdst: REGDST_RT};
            unique case (dinstr.op)
                OP_SLTI:  arith.alu_func = ALU_SLT;
                OP_SLTIU: arith.alu_func = ALU_SLTU;
                OP_ANDI:  arith.alu_func = ALU_AND;
                OP_ORI:   arith.alu_func = ALU_OR;
                OP_XORI:  arith.alu_func = ALU_XOR;
                OP_LUI:
                begin
                    arith.out_sel          = OUT_SHIFT;
                    arith.sft_func         = SFT_LUI;
                    arith.sft_srca_sel_imm = 1'b1;  // Imm shifted into upper half
                end
                default:  arith.alu_func = ALU_ADD;  // ADDI, ADDIU
            endcase
            // Logical immediates stay zero extended
            arith.imm_sign  = dinstr.op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU};
            arith.intovf_en = (dinstr.op == OP_ADDI);
        end
        default: claim = 1'b0;
    endcase
end

endmodule

`default_nettype wire

// File: hdl/flow_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module flow_decoder
    import isa_pkg::*, ctrl_pkg::*;
(
    input  instr_t     dinstr,
    output flow_ctrl_t flow,
    output wb_ctrl_t   wb,
    output logic       claim
);

always_comb
begin
    flow  = '0;
    wb    = '0;
    claim = 1'b1;
    unique case (dinstr.op)
        OP_BEQ:  flow.branch = BR_BEQ;
        OP_BNE:  flow.branch = BR_BNE;
        OP_BGTZ: flow.branch = BR_BGTZ;
        OP_BLEZ: flow.branch = BR_BLEZ;
        OP_REGIMM:
        begin
            unique case (dinstr.rt)
                RI_BGEZ:   flow.branch = BR_BGEZ;
                RI_BLTZ:   flow.branch = BR_BLTZ;
                RI_BGEZAL: flow.branch = BR_BGEZAL;
                RI_BLTZAL: flow.branch = BR_BLTZAL;
                default:   claim       = 1'b0;
            endcase
        end
        OP_J:    flow.jump = JMP_J;
        OP_JAL:  flow.jump = JMP_JAL;
        OP_SPECIAL:
        begin
            unique case (dinstr.funct)
                FN_JR:      flow.jump       = JMP_JR;
                FN_JALR:    flow.jump       = JMP_JALR;
                FN_BREAK:   flow.mips_break = 1'b1;
                FN_SYSCALL: flow.syscall    = 1'b1;
                FN_SYNC:    ;  // Plain no-op
                default:    claim           = 1'b0;
            endcase
        end
        default: claim = 1'b0;
    endcase

    if (claim)
    begin
        flow.isbranch = dinstr.op inside {OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ, OP_REGIMM};
        flow.isjump   = dinstr.op inside {OP_J, OP_JAL}
                        || (dinstr.op == OP_SPECIAL && dinstr.funct inside {FN_JR, FN_JALR});
        flow.link     = (flow.isbranch && flow.branch inside {BR_BGEZAL, BR_BLTZAL})
                        || (flow.isjump && flow.jump inside {JMP_JAL, JMP_JALR});
    end

    // Return address goes to $ra, except JALR names its own rd
    if (flow.link)
    begin
        wb.regwrite = 1'b1;
        wb.regdst   = (flow.isjump && flow.jump == JMP_JALR) ? REGDST_RD : REGDST_RA;
    end
end

endmodule

`default_nettype wire

// File: hdl/mem_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module mem_decoder
    import isa_pkg::*, ctrl_pkg::*;
(
    input  instr_t    dinstr,
    output mem_ctrl_t mem,
    output wb_ctrl_t  wb,
    output logic      claim
);

always_comb
begin
    mem   = '0;
    wb    = '0;
    claim = 1'b1;
    unique case (dinstr.op)
        OP_LB, OP_LBU, OP_SB: mem.size = SIZE_BYTE;
        OP_LH, OP_LHU, OP_SH: mem.size = SIZE_HALF;
        OP_LW, OP_SW:         mem.size = SIZE_WORD;
        default:              claim    = 1'b0;
    endcase

    mem.memreq     = claim;
    mem.memwr      = dinstr.op inside {OP_SB, OP_SH, OP_SW};
    mem.rdata_sign = dinstr.op inside {OP_LB, OP_LH, OP_LW};  // Sign extend load data
    mem.memtoreg   = claim && !mem.memwr;

    // Loads write rt
    wb.regwrite = mem.memtoreg;
    wb.regdst   = REGDST_RT;
end

endmodule

`default_nettype wire

// File: hdl/muldiv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_decoder
    import isa_pkg::*, ctrl_pkg::*;
(
    input  instr_t       dinstr,
    output muldiv_ctrl_t muldiv,
    output logic         arith_mul,
    output wb_ctrl_t     wb,
    output logic         claim
);

always_comb
begin
    muldiv    = '0;
    arith_mul = 1'b0;
    wb        = '0;
    claim     = 1'b1;
    unique case (dinstr.op)
        OP_SPECIAL:
        begin
            unique case (dinstr.funct)
                FN_MULT, FN_MULTU:
                begin
                    muldiv.mul_en   = 1'b1;
                    muldiv.mul_sign = (dinstr.funct == FN_MULT);
                    muldiv.hi_wen   = 1'b1;
                    muldiv.lo_wen   = 1'b1;
                end
                FN_DIV, FN_DIVU:
                begin
                    muldiv.div_en   = 1'b1;
                    muldiv.div_sign = (dinstr.funct == FN_DIV);
                    muldiv.hi_sel   = HILO_DIV;
                    muldiv.lo_sel   = HILO_DIV;
                    muldiv.hi_wen   = 1'b1;
                    muldiv.lo_wen   = 1'b1;
                end
                // Word itself is claimed by arith_decoder
                FN_MTHI:
                begin
                    muldiv.hi_sel = HILO_REG;
                    muldiv.hi_wen = 1'b1;
                    claim         = 1'b0;
                end
                FN_MTLO:
                begin
                    muldiv.lo_sel = HILO_REG;
                    muldiv.lo_wen = 1'b1;
                    claim         = 1'b0;
                end
                default: claim = 1'b0;
            endcase
        end
        OP_SPECIAL2:
        begin
            unique case (dinstr.funct)
                F2_MUL:
                begin
                    arith_mul = 1'b1;  // Low word to rd, HI/LO untouched
                    wb        = '{regwrite: 1'b1, regdst: REGDST_RD};
                end
                F2_MADD, F2_MADDU: muldiv.mul_mode = MUL_ACC_ADD;
                F2_MSUB, F2_MSUBU: muldiv.mul_mode = MUL_ACC_SUB;
                default:           claim           = 1'b0;
            endcase
            if (claim)
            begin
                muldiv.mul_en   = 1'b1;
                muldiv.mul_sign = dinstr.funct inside {F2_MUL, F2_MADD, F2_MSUB};
                muldiv.hi_wen   = !arith_mul;
                muldiv.lo_wen   = !arith_mul;
            end
        end
        default: claim = 1'b0;
    endcase
end

endmodule

`default_nettype wire

// File: hdl/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
    import isa_pkg::*, ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  instr_t  dinstr,
    input  logic    stall,
    input  logic    flush,
    output dstage_t dstage
);

arith_ctrl_t  arith_a;
arith_ctrl_t  arith_mem;
arith_ctrl_t  arith_md;
flow_ctrl_t   flow;
mem_ctrl_t    mem;
muldiv_ctrl_t muldiv;
logic         arith_mul;
wb_ctrl_t     wb_a;
wb_ctrl_t     wb_f;
wb_ctrl_t     wb_m;
wb_ctrl_t     wb_md;
logic         claim_a;
logic         claim_f;
logic         claim_m;
logic         claim_md;
dstage_t      decoded;

arith_decoder u_arith (
    .dinstr (dinstr),
    .arith  (arith_a),
    .wb     (wb_a),
    .claim  (claim_a)
);

flow_decoder u_flow (
    .dinstr (dinstr),
    .flow   (flow),
    .wb     (wb_f),
    .claim  (claim_f)
);

mem_decoder u_mem (
    .dinstr (dinstr),
    .mem    (mem),
    .wb     (wb_m),
    .claim  (claim_m)
);

muldiv_decoder u_muldiv (
    .dinstr    (dinstr),
    .muldiv    (muldiv),
    .arith_mul (arith_mul),
    .wb        (wb_md),
    .claim     (claim_md)
);

// Arithmetic needs of words owned by other decoders
always_comb
begin
    arith_mem          = '0;
    arith_mem.alu_func = ALU_ADD;  // Base plus offset
    arith_mem.imm_sign = mem.memreq;
    arith_md           = '0;
    arith_md.out_sel   = arith_mul ? OUT_MUL : OUT_ALU;
end

// Unclaimed groups are all zero, so OR merges them
always_comb
begin
    decoded.arith          = arith_ctrl_t'(arith_a | arith_mem | arith_md);
    decoded.flow           = flow;
    decoded.mem            = mem;
    decoded.muldiv         = muldiv;
    decoded.wb             = wb_ctrl_t'(wb_a | wb_f | wb_m | wb_md);
    decoded.reserved_instr = !(claim_a || claim_f || claim_m || claim_md);
end

always_ff @(posedge clk or negedge arst_n)
begin
    if (!arst_n)
        dstage <= '0;
    else if (!stall)  // Stall holds, even over flush
    begin
        if (flush)
            dstage <= '0;  // Bubble
        else
            dstage <= decoded;
    end
end

endmodule

`default_nettype wire

// File: sim/decoder_properties.sv
`timescale 1ns/1ps
`default_nettype none

module decoder_properties
    import ctrl_pkg::*;
(
    input wire logic    clk,
    input wire logic    arst_n,
    input wire logic    stall,
    input wire logic    flush,
    input wire dstage_t dstage
);

// A store is always a memory request
store_has_req: assert property (
    @(posedge clk) disable iff (!arst_n)
    dstage.mem.memwr |-> dstage.mem.memreq
) else $error("memwr set without memreq");

// Back-pressure holds the stage register
stall_holds: assert property (
    @(posedge clk) disable iff (!arst_n)
    stall |=> $stable(dstage)
) else $error("dstage changed during stall");

flush_bubble: assert property (
    @(posedge clk) disable iff (!arst_n)
    (flush && !stall) |=> (dstage == '0)
) else $error("flush did not give a bubble");

// Reserved words must not change any state
reserved_no_write: assert property (
    @(posedge clk) disable iff (!arst_n)
    dstage.reserved_instr |-> !dstage.wb.regwrite && !dstage.mem.memreq
                              && !dstage.muldiv.hi_wen && !dstage.muldiv.lo_wen
) else $error("reserved instruction with a write enabled");

endmodule

bind instr_decoder decoder_properties u_props (
    .clk    (clk),
    .arst_n (arst_n),
    .stall  (stall),
    .flush  (flush),
    .dstage (dstage)
);

`default_nettype wire

// File: sim/tb_instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_instr_decoder
    import isa_pkg::*, ctrl_pkg::*;
;

localparam int RUN_CYCLES   = 2000;
localparam int WATCHDOG_CYC = 2500;

logic    clk;
logic    arst_n;
instr_t  dinstr;
logic    stall;
logic    flush;
dstage_t dstage;
dstage_t expected;
string   test_name;

// Kept primary opcodes, SPECIAL functs, REGIMM rt codes, SPECIAL2 functs
logic [5:0] main_ops [25] = '{6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07,
    6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h1c,
    6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b};
logic [5:0] spec_fns [29] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09,
    6'h0c, 6'h0d, 6'h0f, 6'h10, 6'h11, 6'h12, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b,
    6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
logic [4:0] regimm_rts [4] = '{5'h00, 5'h01, 5'h10, 5'h11};
logic [5:0] spec2_fns [5]  = '{6'h00, 6'h01, 6'h02, 6'h04, 6'h05};
// TLBWI, CACHE, CLO, LWL
logic [31:0] dropped [4] = '{32'h4200_0002, 32'hbc00_0000, 32'h7000_0021, 32'h8800_0000};

instr_decoder dut (
    .clk    (clk),
    .arst_n (arst_n),
    .dinstr (dinstr),
    .stall  (stall),
    .flush  (flush),
    .dstage (dstage)
);

always #5 clk = ~clk;

// ALU operation shared by R-type functs and immediate opcodes
function automatic alu_func_e alu_of(logic [5:0] code);
    case (code)
        6'h22, 6'h23: return ALU_SUB;
        6'h2a, 6'h0a: return ALU_SLT;
        6'h2b, 6'h0b: return ALU_SLTU;
        6'h24, 6'h0c: return ALU_AND;
        6'h25, 6'h0d: return ALU_OR;
        6'h26, 6'h0e: return ALU_XOR;
        6'h27:        return ALU_NOR;
        default:      return ALU_ADD;
    endcase
endfunction

function automatic wb_ctrl_t write_to(regdst_e dst);
    wb_ctrl_t wb;
    wb.regwrite = 1'b1;
    wb.regdst   = dst;
    return wb;
endfunction

function automatic dstage_t expect_ctrl(instr_t w);
    dstage_t    d;
    logic [5:0] f;
    d = '0;
    f = w.funct;
    case (w.op)
        OP_SPECIAL:
            case (f)
                6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b:
                begin
                    d.arith.alu_func        = alu_of(f);
                    d.arith.alu_srcb_sel_rt = 1'b1;
                    d.arith.intovf_en       = (f == 6'h20 || f == 6'h22);  // ADD, SUB
                    d.wb                    = write_to(REGDST_RD);
                end
                6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07:
                begin
                    d.arith.sft_func = (f[1:0] == 2'b00) ? SFT_SLL
                                     : (f[1:0] == 2'b10) ? SFT_SRL : SFT_SRA;
                    d.arith.out_sel         = OUT_SHIFT;
                    d.arith.sft_srcb_sel_rs = f[2];  // Variable shifts
                    d.wb                    = write_to(REGDST_RD);
                end
                6'h10, 6'h12:
                begin
                    d.arith.out_sel = (f == 6'h10) ? OUT_HI : OUT_LO;
                    d.wb            = write_to(REGDST_RD);
                end
                6'h11:
                begin
                    d.muldiv.hi_sel = HILO_REG;
                    d.muldiv.hi_wen = 1'b1;
                end
                6'h13:
                begin
                    d.muldiv.lo_sel = HILO_REG;
                    d.muldiv.lo_wen = 1'b1;
                end
                6'h08:
                begin
                    d.flow.isjump = 1'b1;
                    d.flow.jump   = JMP_JR;
                end
                6'h09:
                begin
                    d.flow.isjump = 1'b1;
                    d.flow.jump   = JMP_JALR;
                    d.flow.link   = 1'b1;
                    d.wb          = write_to(REGDST_RD);
                end
                6'h0c, 6'h0d, 6'h0f:
                begin
                    d.flow.syscall    = (f == 6'h0c);
                    d.flow.mips_break = (f == 6'h0d);
                end
                6'h18, 6'h19, 6'h1a, 6'h1b:
                begin
                    d.muldiv.mul_en   = !f[1];
                    d.muldiv.div_en   = f[1];
                    d.muldiv.mul_sign = !f[1] && !f[0];
                    d.muldiv.div_sign = f[1] && !f[0];
                    d.muldiv.hi_sel   = f[1] ? HILO_DIV : HILO_MULDIV;
                    d.muldiv.lo_sel   = f[1] ? HILO_DIV : HILO_MULDIV;
                    d.muldiv.hi_wen   = 1'b1;
                    d.muldiv.lo_wen   = 1'b1;
                end
                default: d.reserved_instr = 1'b1;
            endcase
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI:
        begin
            d.arith.alu_func  = alu_of(w.op);
            d.arith.imm_sign  = (w.op[5:2] == 4'b0010);  // ADDI to SLTIU
            d.arith.intovf_en = (w.op == OP_ADDI);
            d.wb              = write_to(REGDST_RT);
        end
        OP_LUI:
        begin
            d.arith.out_sel          = OUT_SHIFT;
            d.arith.sft_func         = SFT_LUI;
            d.arith.sft_srca_sel_imm = 1'b1;
            d.wb                     = write_to(REGDST_RT);
        end
        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ:
        begin
            d.flow.isbranch = 1'b1;
            d.flow.branch   = (w.op == OP_BEQ) ? BR_BEQ : (w.op == OP_BNE) ? BR_BNE
                            : (w.op == OP_BLEZ) ? BR_BLEZ : BR_BGTZ;
        end
        OP_REGIMM:
            if (w.rt inside {5'h00, 5'h01, 5'h10, 5'h11})
            begin
                d.flow.isbranch = 1'b1;
                d.flow.branch   = w.rt[4] ? (w.rt[0] ? BR_BGEZAL : BR_BLTZAL)
                                          : (w.rt[0] ? BR_BGEZ : BR_BLTZ);
                d.flow.link     = w.rt[4];
                if (w.rt[4])
                    d.wb = write_to(REGDST_RA);
            end
            else
                d.reserved_instr = 1'b1;
        OP_J, OP_JAL:
        begin
            d.flow.isjump = 1'b1;
            d.flow.jump   = (w.op == OP_J) ? JMP_J : JMP_JAL;
            d.flow.link   = (w.op == OP_JAL);
            if (w.op == OP_JAL)
                d.wb = write_to(REGDST_RA);
        end
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW:
        begin
            d.arith.imm_sign  = 1'b1;  // Base plus signed offset
            d.mem.memreq      = 1'b1;
            d.mem.memwr       = w.op[3];
            d.mem.size        = (w.op[1:0] == 2'b11) ? SIZE_WORD
                              : (w.op[1:0] == 2'b01) ? SIZE_HALF : SIZE_BYTE;
            d.mem.rdata_sign  = !w.op[3] && !w.op[2];
            d.mem.memtoreg    = !w.op[3];
            d.wb.regwrite     = !w.op[3];
        end
        OP_SPECIAL2:
            if (f == 6'h02)
            begin
                d.muldiv.mul_en   = 1'b1;
                d.muldiv.mul_sign = 1'b1;
                d.arith.out_sel   = OUT_MUL;
                d.wb              = write_to(REGDST_RD);
            end
            else if (f inside {6'h00, 6'h01, 6'h04, 6'h05})
            begin
                d.muldiv.mul_en   = 1'b1;
                d.muldiv.mul_sign = !f[0];
                d.muldiv.mul_mode = f[2] ? MUL_ACC_SUB : MUL_ACC_ADD;
                d.muldiv.hi_wen   = 1'b1;
                d.muldiv.lo_wen   = 1'b1;
            end
            else
                d.reserved_instr = 1'b1;
        default: d.reserved_instr = 1'b1;
    endcase
    return d;
endfunction

function automatic instr_t next_word();
    instr_t w;
    w = instr_t'($urandom);
    if ($urandom % 8 == 0)
    begin
        if ($urandom % 2 == 0)
            w = instr_t'(dropped[$urandom % 4] | ($urandom & 32'h03ff_f800));
        return w;  // Fully random word otherwise
    end
    w.op = opcode_e'(main_ops[$urandom % 25]);
    if (w.op == OP_SPECIAL)
        w.funct = spec_fns[$urandom % 29];
    else if (w.op == OP_REGIMM)
        w.rt = regimm_rts[$urandom % 4];
    else if (w.op == OP_SPECIAL2)
        w.funct = spec2_fns[$urandom % 5];
    return w;
endfunction

task automatic check_stage(string name);
    if (dstage !== expected)
    begin
        $display("FAIL %s expected %h actual %h", name, expected, dstage);
        $display("Something failed");
        $fatal(1, "dstage mismatch");
    end
endtask

initial
begin
    void'($urandom(32'h3b30));
    clk      = 1'b0;
    arst_n   = 1'b0;
    dinstr   = '0;
    stall    = 1'b0;
    flush    = 1'b0;
    expected = '0;
    for (int i = 0; i < 2; i++)
    begin
        @(negedge clk);
        check_stage("reset");
    end
    @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_stage("reset release");
    for (int cyc = 0; cyc < RUN_CYCLES; cyc++)
    begin
        @(posedge clk);
        // Inputs still hold what the DUT sampled on this edge
        test_name = stall ? "stall" : (flush ? "flush" : "decode");
        if (!stall)
            expected = flush ? '0 : expect_ctrl(dinstr);
        dinstr <= next_word();
        stall  <= ($urandom % 6 == 0);
        flush  <= ($urandom % 6 == 0);
        @(negedge clk);
        check_stage(test_name);
    end
    $display("Everything OK");
    $finish;
end

initial
begin
    for (int i = 0; i < WATCHDOG_CYC; i++)
        @(posedge clk);
    $display("Timeout: run did not complete in %0d cycles", WATCHDOG_CYC);
    $display("Something failed");
    $fatal(1, "timeout");
end

endmodule

`default_nettype wire

// File: filelist.f
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/arith_decoder.sv
hdl/flow_decoder.sv
hdl/mem_decoder.sv
hdl/muldiv_decoder.sv
hdl/instr_decoder.sv
sim/decoder_properties.sv
sim/tb_instr_decoder.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f filelist.f \
        --top-module tb_instr_decoder -o tb_sim; then
    echo "Build failed"
    exit 1
fi

output=$(./obj_dir/tb_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Everything OK$"; then
    exit 0
fi
echo "Pass message not found"
exit 1
